// File: src/mulDivOpPkg.sv
package mulDivOpPkg;

  // reference encoding of the M extension ops
  typedef enum logic [2:0] {
    opMul    = 3'b000,
    opMulh   = 3'b001,
    opMulhsu = 3'b010,
    opMulhu  = 3'b011,
    opDiv    = 3'b100,
    opDivu   = 3'b101,
    opRem    = 3'b110,
    opRemu   = 3'b111
  } opCodeT;

  function automatic logic isDivOp(input opCodeT op);
    return op inside {opDiv, opDivu, opRem, opRemu};
  endfunction

  // lOp is multiplier or divisor
  function automatic logic lOpSigned(input opCodeT op);
    return op inside {opMulh, opDiv, opRem};
  endfunction

  // rOp is multiplicand or dividend
  function automatic logic rOpSigned(input opCodeT op);
    return op inside {opMulh, opMulhsu, opDiv, opRem};
  endfunction

  function automatic logic wantsHigh(input opCodeT op);
    return op inside {opMulh, opMulhsu, opMulhu};
  endfunction

  function automatic logic wantsRemainder(input opCodeT op);
    return op inside {opRem, opRemu};
  endfunction

endpackage

// File: src/mulDivCtrlPkg.sv
package mulDivCtrlPkg;

  // four-phase handshake side of a stage
  typedef enum logic [1:0] {
    stIdle,
    stBusy,
    stOffer,
    stRelease
  } stageStateT;

  // iteration sequencer of the kernel
  typedef enum logic [1:0] {
    kIdle,
    kRun,
    kDone
  } kernelStateT;

endpackage

// File: src/operandPrep.sv
`timescale 1ns/1ps

module operandPrep
  import mulDivOpPkg::*;
  import mulDivCtrlPkg::*;
#(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 inReq,
  output logic                 inAck,
  input  opCodeT               opCode,
  input  logic [dataWidth-1:0] lOp,
  input  logic [dataWidth-1:0] rOp,
  output logic                 prepReq,
  input  logic                 prepAck,
  output opCodeT               prepOp,
  output logic [dataWidth-1:0] magR,
  output logic [dataWidth-1:0] magL,
  output logic                 negProduct,
  output logic                 negQuot,
  output logic                 negRem,
  output logic                 divByZero,
  output logic                 divOverflow
);

  stageStateT state;
  logic capture;
  logic divOp;
  logic negR;
  logic negL;
  logic lIsZero;
  logic lIsMinusOne;
  logic rIsMostNeg;

  assign divOp = isDivOp(opCode);
  assign negR = rOpSigned(opCode) && rOp[dataWidth-1];
  assign negL = lOpSigned(opCode) && lOp[dataWidth-1];

  assign lIsZero = (lOp == '0);
  assign lIsMinusOne = (lOp == '1);
  assign rIsMostNeg = (rOp == {1'b1, {(dataWidth-1){1'b0}}});

  // take a new set only with an empty buffer and the last ack gone
  assign capture = (state == stIdle) && inReq && !inAck;
  assign prepReq = (state == stOffer);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= stIdle;
      inAck <= 1'b0;
    end else begin
      if (capture) begin
        inAck <= 1'b1;
      end else if (!inReq) begin
        inAck <= 1'b0;
      end

      case (state)
        stIdle: begin
          if (capture) begin
            state <= stOffer;
          end
        end
        stOffer: begin
          if (prepAck) begin
            state <= stRelease;
          end
        end
        stRelease: begin
          // buffer frees once the kernel drops its ack
          if (!prepAck) begin
            state <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      prepOp <= opCode;
      magR <= negR ? -rOp : rOp;
      magL <= negL ? -lOp : lOp;
      negProduct <= !divOp && (negR ^ negL);
      negQuot <= divOp && (negR ^ negL);
      negRem <= divOp && negR;
      divByZero <= divOp && lIsZero;
      // most negative over minus one, signed divides only
      divOverflow <= divOp && lOpSigned(opCode) && lIsMinusOne && rIsMostNeg;
    end
  end

endmodule

// File: src/iterKernel.sv
`timescale 1ns/1ps

module iterKernel
  import mulDivOpPkg::*;
  import mulDivCtrlPkg::*;
#(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 prepReq,
  output logic                 prepAck,
  input  opCodeT               prepOp,
  input  logic [dataWidth-1:0] magR,
  input  logic [dataWidth-1:0] magL,
  input  logic                 negProduct,
  input  logic                 negQuot,
  input  logic                 negRem,
  input  logic                 divByZero,
  input  logic                 divOverflow,
  output logic                 kernReq,
  input  logic                 kernAck,
  output opCodeT               kernOp,
  output logic [dataWidth-1:0] prodHi,
  output logic [dataWidth-1:0] prodLo,
  output logic [dataWidth-1:0] quotient,
  output logic [dataWidth-1:0] remainder,
  output logic [dataWidth-1:0] origR,
  output logic                 negProductOut,
  output logic                 negQuotOut,
  output logic                 negRemOut,
  output logic                 divByZeroOut,
  output logic                 divOverflowOut
);

  localparam int cntWidth = $clog2(dataWidth);
  localparam logic [cntWidth-1:0] lastStep = cntWidth'(dataWidth - 1);

  kernelStateT kState;
  stageStateT ackState;
  logic [cntWidth-1:0] stepCnt;
  logic capture;

  // opndReg holds multiplicand or divisor, shReg the other operand
  logic [dataWidth-1:0] opndReg;
  logic [dataWidth-1:0] accReg;
  logic [dataWidth-1:0] shReg;
  logic [dataWidth-1:0] addend;
  logic [dataWidth:0] addSum;
  logic [dataWidth:0] trial;

  assign capture = (kState == kIdle) && (ackState == stIdle) && prepReq;
  assign prepAck = (ackState == stBusy);
  assign kernReq = (kState == kDone);

  // shift-add step
  assign addend = shReg[0] ? opndReg : '0;
  assign addSum = {1'b0, accReg} + {1'b0, addend};

  // restoring step, top bit set means borrow
  assign trial = {accReg, shReg[dataWidth-1]} - {1'b0, opndReg};

  always_ff @(posedge clk) begin
    if (!rstN) begin
      kState <= kIdle;
      ackState <= stIdle;
      stepCnt <= '0;
    end else begin
      case (ackState)
        stIdle: begin
          if (capture) begin
            ackState <= stBusy;
          end
        end
        stBusy: begin
          if (!prepReq) begin
            ackState <= stIdle;
          end
        end
        default: ackState <= stIdle;
      endcase

      case (kState)
        kIdle: begin
          if (capture) begin
            kState <= kRun;
            stepCnt <= '0;
          end
        end
        kRun: begin
          stepCnt <= stepCnt + 1'b1;
          if (stepCnt == lastStep) begin
            kState <= kDone;
          end
        end
        kDone: begin
          if (kernAck) begin
            kState <= kIdle;
          end
        end
        default: kState <= kIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      kernOp <= prepOp;
      origR <= magR;
      accReg <= '0;
      if (isDivOp(prepOp)) begin
        opndReg <= magL;
        shReg <= magR;
      end else begin
        opndReg <= magR;
        shReg <= magL;
      end
      negProductOut <= negProduct;
      negQuotOut <= negQuot;
      negRemOut <= negRem;
      divByZeroOut <= divByZero;
      divOverflowOut <= divOverflow;
    end else if (kState == kRun) begin
      if (isDivOp(kernOp)) begin
        // dividend bits leave at the top, quotient bits enter at the bottom
        if (trial[dataWidth]) begin
          accReg <= {accReg[dataWidth-2:0], shReg[dataWidth-1]};
        end else begin
          accReg <= trial[dataWidth-1:0];
        end
        shReg <= {shReg[dataWidth-2:0], !trial[dataWidth]};
      end else begin
        accReg <= addSum[dataWidth:1];
        shReg <= {addSum[0], shReg[dataWidth-1:1]};
      end
    end
  end

  // product and division results share the same pair of registers
  assign prodHi = accReg;
  assign remainder = accReg;
  assign prodLo = shReg;
  assign quotient = shReg;

endmodule

// File: src/resultSelect.sv
`timescale 1ns/1ps

module resultSelect
  import mulDivOpPkg::*;
  import mulDivCtrlPkg::*;
#(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 kernReq,
  output logic                 kernAck,
  input  opCodeT               kernOp,
  input  logic [dataWidth-1:0] prodHi,
  input  logic [dataWidth-1:0] prodLo,
  input  logic [dataWidth-1:0] quotient,
  input  logic [dataWidth-1:0] remainder,
  input  logic [dataWidth-1:0] origR,
  input  logic                 negProduct,
  input  logic                 negQuot,
  input  logic                 negRem,
  input  logic                 divByZero,
  input  logic                 divOverflow,
  output logic                 outReq,
  input  logic                 outAck,
  output logic [dataWidth-1:0] result,
  output logic                 divByZeroOut,
  output logic                 divOverflowOut
);

  stageStateT state;
  logic capture;
  opCodeT capOp;
  logic [dataWidth-1:0] capHi;
  logic [dataWidth-1:0] capLo;
  logic [dataWidth-1:0] capOrigR;
  logic capNegProduct;
  logic capNegQuot;
  logic capNegRem;
  logic capDivByZero;
  logic capDivOverflow;
  logic [2*dataWidth-1:0] product;
  logic [2*dataWidth-1:0] productFix;
  logic [dataWidth-1:0] quotFix;
  logic [dataWidth-1:0] remFix;
  logic [dataWidth-1:0] dividend;
  logic [dataWidth-1:0] word;

  assign capture = (state == stIdle) && kernReq && !kernAck;
  assign outReq = (state == stOffer);

  assign product = {capHi, capLo};
  assign productFix = capNegProduct ? -product : product;
  assign quotFix = capNegQuot ? -capLo : capLo;
  assign remFix = capNegRem ? -capHi : capHi;
  // remainder sign is the dividend sign
  assign dividend = capNegRem ? -capOrigR : capOrigR;

  always_comb begin
    if (wantsHigh(capOp)) begin
      word = productFix[2*dataWidth-1:dataWidth];
    end else if (!isDivOp(capOp)) begin
      word = productFix[dataWidth-1:0];
    end else if (wantsRemainder(capOp)) begin
      if (capDivByZero) begin
        word = dividend;
      end else if (capDivOverflow) begin
        word = '0;
      end else begin
        word = remFix;
      end
    end else begin
      if (capDivByZero) begin
        word = '1;
      end else if (capDivOverflow) begin
        word = dividend;
      end else begin
        word = quotFix;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= stIdle;
      kernAck <= 1'b0;
    end else begin
      if (capture) begin
        kernAck <= 1'b1;
      end else if (!kernReq) begin
        kernAck <= 1'b0;
      end

      case (state)
        stIdle: begin
          if (capture) begin
            state <= stBusy;
          end
        end
        stBusy: state <= stOffer;
        stOffer: begin
          if (outAck) begin
            state <= stRelease;
          end
        end
        stRelease: begin
          if (!outAck) begin
            state <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      capOp <= kernOp;
      capHi <= isDivOp(kernOp) ? remainder : prodHi;
      capLo <= isDivOp(kernOp) ? quotient : prodLo;
      capOrigR <= origR;
      capNegProduct <= negProduct;
      capNegQuot <= negQuot;
      capNegRem <= negRem;
      capDivByZero <= divByZero;
      capDivOverflow <= divOverflow;
    end
    // output word settles one cycle after capture
    if (state == stBusy) begin
      result <= word;
      divByZeroOut <= capDivByZero;
      divOverflowOut <= capDivOverflow;
    end
  end

endmodule

// File: src/mulDivUnit.sv
`timescale 1ns/1ps

module mulDivUnit
  import mulDivOpPkg::*;
#(
  parameter int dataWidth = 32
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 inReq,
  output logic                 inAck,
  input  opCodeT               opCode,
  input  logic [dataWidth-1:0] lOp,
  input  logic [dataWidth-1:0] rOp,
  output logic                 outReq,
  input  logic                 outAck,
  output logic [dataWidth-1:0] result,
  output logic                 divByZero,
  output logic                 divOverflow
);

  // prep to kernel
  logic prepReq;
  logic prepAck;
  opCodeT prepOp;
  logic [dataWidth-1:0] magR;
  logic [dataWidth-1:0] magL;
  logic prepNegProduct;
  logic prepNegQuot;
  logic prepNegRem;
  logic prepDivByZero;
  logic prepDivOverflow;

  // kernel to result
  logic kernReq;
  logic kernAck;
  opCodeT kernOp;
  logic [dataWidth-1:0] prodHi;
  logic [dataWidth-1:0] prodLo;
  logic [dataWidth-1:0] quotient;
  logic [dataWidth-1:0] remainder;
  logic [dataWidth-1:0] origR;
  logic kernNegProduct;
  logic kernNegQuot;
  logic kernNegRem;
  logic kernDivByZero;
  logic kernDivOverflow;

  operandPrep #(.dataWidth(dataWidth)) u0Prep (
    .clk(clk), .rstN(rstN), .inReq(inReq), .inAck(inAck), .opCode(opCode),
    .lOp(lOp), .rOp(rOp), .prepReq(prepReq), .prepAck(prepAck), .prepOp(prepOp),
    .magR(magR), .magL(magL), .negProduct(prepNegProduct), .negQuot(prepNegQuot),
    .negRem(prepNegRem), .divByZero(prepDivByZero), .divOverflow(prepDivOverflow)
  );

  iterKernel #(.dataWidth(dataWidth)) u1Kernel (
    .clk(clk), .rstN(rstN), .prepReq(prepReq), .prepAck(prepAck), .prepOp(prepOp),
    .magR(magR), .magL(magL), .negProduct(prepNegProduct), .negQuot(prepNegQuot),
    .negRem(prepNegRem), .divByZero(prepDivByZero), .divOverflow(prepDivOverflow),
    .kernReq(kernReq), .kernAck(kernAck), .kernOp(kernOp), .prodHi(prodHi),
    .prodLo(prodLo), .quotient(quotient), .remainder(remainder), .origR(origR),
    .negProductOut(kernNegProduct), .negQuotOut(kernNegQuot), .negRemOut(kernNegRem),
    .divByZeroOut(kernDivByZero), .divOverflowOut(kernDivOverflow)
  );

  resultSelect #(.dataWidth(dataWidth)) u2Result (
    .clk(clk), .rstN(rstN), .kernReq(kernReq), .kernAck(kernAck), .kernOp(kernOp),
    .prodHi(prodHi), .prodLo(prodLo), .quotient(quotient), .remainder(remainder),
    .origR(origR), .negProduct(kernNegProduct), .negQuot(kernNegQuot),
    .negRem(kernNegRem), .divByZero(kernDivByZero), .divOverflow(kernDivOverflow),
    .outReq(outReq), .outAck(outAck), .result(result), .divByZeroOut(divByZero),
    .divOverflowOut(divOverflow)
  );

endmodule

// File: include/mulDivTbRef.svh
`ifndef MULDIVTBREF_SVH
`define MULDIVTBREF_SVH

// opcode values on the testbench side, same encoding as the DUT
localparam int refWidth = 32;
localparam logic [2:0] refMul = 3'b000;
localparam logic [2:0] refMulh = 3'b001;
localparam logic [2:0] refMulhsu = 3'b010;
localparam logic [2:0] refMulhu = 3'b011;
localparam logic [2:0] refDiv = 3'b100;
localparam logic [2:0] refDivu = 3'b101;
localparam logic [2:0] refRem = 3'b110;
localparam logic [2:0] refRemu = 3'b111;

// expected result and flags, rOp is multiplicand or dividend
function automatic void mulDivRef(
  input  logic [2:0]          op,
  input  logic [refWidth-1:0] lOp,
  input  logic [refWidth-1:0] rOp,
  output logic [refWidth-1:0] res,
  output logic                divByZero,
  output logic                divOverflow
);
  logic rSigned;
  logic lSigned;
  logic isDiv;
  logic mostNeg;
  logic [2*refWidth-1:0] rExt;
  logic [2*refWidth-1:0] lExt;
  logic [2*refWidth-1:0] prod;
  rSigned = op inside {refMulh, refMulhsu, refDiv, refRem};
  lSigned = op inside {refMulh, refDiv, refRem};
  isDiv = op[2];
  // sign extended product modulo 2^(2w) is exact in both halves
  rExt = rSigned ? {{refWidth{rOp[refWidth-1]}}, rOp} : {{refWidth{1'b0}}, rOp};
  lExt = lSigned ? {{refWidth{lOp[refWidth-1]}}, lOp} : {{refWidth{1'b0}}, lOp};
  prod = rExt * lExt;
  mostNeg = (rOp == {1'b1, {(refWidth-1){1'b0}}});
  divByZero = isDiv && (lOp == '0);
  divOverflow = isDiv && lSigned && mostNeg && (lOp == '1);
  case (op)
    refMul: res = prod[refWidth-1:0];
    refMulh, refMulhsu, refMulhu: res = prod[2*refWidth-1:refWidth];
    refDiv: begin
      if (divByZero) res = '1;
      else if (divOverflow) res = rOp;
      else res = $signed(rOp) / $signed(lOp);
    end
    refDivu: res = divByZero ? '1 : rOp / lOp;
    refRem: begin
      if (divByZero) res = rOp;
      else if (divOverflow) res = '0;
      else res = $signed(rOp) % $signed(lOp);
    end
    default: res = divByZero ? rOp : rOp % lOp;
  endcase
endfunction

`endif

// File: dv/mulDivTb.sv
`timescale 1ns/1ps

module mulDivTb
  import mulDivOpPkg::*;
();

  `include "mulDivTbRef.svh"

  localparam int waitLimit = 400;
  localparam int randomOps = 300;

  logic clk;
  logic rstN;
  logic inReq;
  logic inAck;
  opCodeT opCode;
  logic [refWidth-1:0] lOp;
  logic [refWidth-1:0] rOp;
  logic outReq;
  logic outAck;
  logic [refWidth-1:0] result;
  logic divByZero;
  logic divOverflow;

  logic [refWidth-1:0] expResQ[$];
  logic expZeroQ[$];
  logic expOvfQ[$];
  logic stimDone;
  int gotCount;

  mulDivUnit #(.dataWidth(refWidth)) uut (
    .clk(clk), .rstN(rstN), .inReq(inReq), .inAck(inAck), .opCode(opCode),
    .lOp(lOp), .rOp(rOp), .outReq(outReq), .outAck(outAck), .result(result),
    .divByZero(divByZero), .divOverflow(divOverflow)
  );

  always #10 clk = ~clk;

  task automatic stopWithError(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkValue(input logic [refWidth-1:0] got, input logic [refWidth-1:0] exp,
                            input string what);
    if (got !== exp) begin
      stopWithError($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic waitInAck(input logic level);
    int cnt;
    cnt = 0;
    while (inAck !== level) begin
      @(negedge clk);
      cnt++;
      if (cnt > waitLimit) begin
        stopWithError($sformatf("timed out waiting for inAck to become %0b", level));
      end
    end
  endtask

  task automatic waitOutReq(input logic level);
    int cnt;
    cnt = 0;
    while (outReq !== level) begin
      @(negedge clk);
      cnt++;
      if (cnt > waitLimit) begin
        stopWithError($sformatf("timed out waiting for outReq to become %0b", level));
      end
    end
  endtask

  // a result after the last expected one would be a duplicate
  task automatic expectQuietOutput();
    for (int i = 0; i < 4 * refWidth; i++) begin
      @(negedge clk);
      if (outReq !== 1'b0) begin
        stopWithError($sformatf("an extra result appeared after all %0d results", gotCount));
      end
    end
  endtask

  // corner values show up often
  function automatic logic [refWidth-1:0] pickOperand();
    case ($urandom % 8)
      0: return '0;
      1: return {1'b1, {(refWidth-1){1'b0}}};
      2: return '1;
      3: return refWidth'(1);
      default: return $urandom;
    endcase
  endfunction

  task automatic sendOp(input opCodeT op, input logic [refWidth-1:0] lVal,
                        input logic [refWidth-1:0] rVal);
    logic [refWidth-1:0] expRes;
    logic expZero;
    logic expOvf;
    mulDivRef(op, lVal, rVal, expRes, expZero, expOvf);
    @(negedge clk);
    opCode = op;
    lOp = lVal;
    rOp = rVal;
    inReq = 1'b1;
    expResQ.push_back(expRes);
    expZeroQ.push_back(expZero);
    expOvfQ.push_back(expOvf);
    waitInAck(1'b1);
    inReq = 1'b0;
    waitInAck(1'b0);
  endtask

  task automatic produceOps();
    logic [refWidth-1:0] mostNeg;
    mostNeg = {1'b1, {(refWidth-1){1'b0}}};
    sendOp(opMul, '1, mostNeg);
    sendOp(opMulh, '1, mostNeg);
    sendOp(opMulhsu, '1, mostNeg);
    sendOp(opMulhu, '1, '1);
    sendOp(opMul, '0, 32'h1234);
    sendOp(opMulh, '0, '1);
    // zero divisor, both dividend signs
    sendOp(opDiv, '0, 32'd12345);
    sendOp(opDivu, '0, 32'd12345);
    sendOp(opRem, '0, -32'sd12345);
    sendOp(opRemu, '0, -32'sd12345);
    sendOp(opDiv, '0, -32'sd7);
    // signed overflow and its unsigned counterparts
    sendOp(opDiv, '1, mostNeg);
    sendOp(opRem, '1, mostNeg);
    sendOp(opDivu, '1, mostNeg);
    sendOp(opRemu, '1, mostNeg);
    sendOp(opDiv, 32'd2, -32'sd7);
    sendOp(opDiv, -32'sd2, 32'd7);
    sendOp(opDiv, -32'sd2, -32'sd7);
    sendOp(opRem, 32'd2, -32'sd7);
    sendOp(opRem, -32'sd2, 32'd7);
    sendOp(opRem, -32'sd2, -32'sd7);
    for (int i = 0; i < randomOps; i++) begin
      sendOp(opCodeT'(3'($urandom % 8)), pickOperand(), pickOperand());
    end
    stimDone = 1'b1;
  endtask

  task automatic consumeResults();
    logic [refWidth-1:0] expRes;
    logic expZero;
    logic expOvf;
    int delay;
    while (!stimDone || expResQ.size() != 0) begin
      waitOutReq(1'b1);
      if (expResQ.size() == 0) begin
        stopWithError("a result arrived with no request outstanding");
      end
      expRes = expResQ.pop_front();
      expZero = expZeroQ.pop_front();
      expOvf = expOvfQ.pop_front();
      checkValue(result, expRes, $sformatf("result %0d", gotCount));
      checkValue({31'b0, divByZero}, {31'b0, expZero}, $sformatf("divByZero %0d", gotCount));
      checkValue({31'b0, divOverflow}, {31'b0, expOvf}, $sformatf("divOverflow %0d", gotCount));
      gotCount++;
      // long stalls now and then to fill the pipeline
      delay = ($urandom % 8 == 0) ? $urandom % 60 : $urandom % 4;
      repeat (delay) @(negedge clk);
      outAck = 1'b1;
      waitOutReq(1'b0);
      outAck = 1'b0;
    end
  endtask

  initial begin
    void'($urandom(55));
    clk = 1'b0;
    rstN = 1'b0;
    inReq = 1'b0;
    opCode = opMul;
    lOp = '0;
    rOp = '0;
    outAck = 1'b0;
    stimDone = 1'b0;
    gotCount = 0;
    repeat (3) begin
      @(negedge clk);
      checkValue({31'b0, inAck}, '0, "inAck in reset");
      checkValue({31'b0, outReq}, '0, "outReq in reset");
    end
    rstN = 1'b1;
    @(negedge clk);
    checkValue({31'b0, inAck}, '0, "inAck after reset");
    checkValue({31'b0, outReq}, '0, "outReq after reset");
    fork
      produceOps();
      consumeResults();
    join
    expectQuietOutput();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: project.f
+incdir+include
src/mulDivOpPkg.sv
src/mulDivCtrlPkg.sv
src/operandPrep.sv
src/iterKernel.sv
src/resultSelect.sv
src/mulDivUnit.sv
dv/mulDivTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --timing -Wno-fatal -f project.f --top-module mulDivTb -o mulDivSim && \
./obj_dir/mulDivSim || { echo "simulation failed"; exit 1; }
